//--- tb.f
+incdir+logic
logic/bus_pkg.sv
logic/irq_pkg.sv
logic/bus_decoder.sv
logic/main_sram.sv
logic/irq_ctrl.sv
logic/hid_receiver.sv
logic/soc_top.sv
test/soc_monitor.sv
test/soc_chk.sv
test/soc_tb.sv

//--- run.sh
#!/bin/sh
# build and run the soc testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module soc_tb -f tb.f -o soc_sim
./obj_dir/soc_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
if grep -q "TEST FAILED" sim.log; then
  echo "simulation reported a failure, see sim.log"
  exit 1
fi
echo "simulation passed"

//--- test/soc_tb.sv
`timescale 1ns/10ps
`include "soc_params.svh"

module soc_tb;

  localparam int max_cycles = 4000; // full run is well under half of this
  localparam int n_sram = 40;
  localparam logic [`ADDR_W-1:0] irq_addr = {`BASE_IRQ, 16'h0000}; // pending register
  localparam logic [`ADDR_W-1:0] hid_addr = {`BASE_HID, 16'h0000};

  logic               clk = 1'b0;
  logic               reset_n;
  logic               hid_clk;
  logic               hid_dat;
  logic               hid_str;
  logic [`IRQ_N-2:0]  ext_irq;
  logic [`ADDR_W-1:0] address;
  logic               read;
  logic               write;
  logic [`DATA_W-1:0] writedata;
  logic [`BE_W-1:0]   byteenable;
  logic [`DATA_W-1:0] readdata;
  logic               waitrequest;
  logic               irq;
  logic [31:0]        lfsr = 32'hc386_25ff;
  logic [31:0]        rnd; // data or index draw
  logic [31:0]        rnd_be; // byte enable draw
  logic [`SRAM_AW-1:0] idx [n_sram]; // sram words under test
  int                 cycles = 0;
  int                 errors_total;

  soc_top dut (.*);

  soc_monitor mon (.*); // all inputs, does the comparing

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("timeout: run still going after %0d clock cycles", max_cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  // galois form, taps 32,22,2,1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic random_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr); // one step per bit
      v = {v[30:0], lfsr[0]};
    end
  endtask

  function automatic logic [`ADDR_W-1:0] sram_addr(input logic [`SRAM_AW-1:0] i);
    return {`BASE_SRAM, 4'h0, i, 2'b00};
  endfunction

  // one bus transfer, request held while waitrequest is high
  task automatic bus_xfer(input logic rd, input logic [`ADDR_W-1:0] a,
                          input logic [`DATA_W-1:0] d, input logic [`BE_W-1:0] be);
    @(negedge clk);
    address = a;
    read = rd;
    write = !rd;
    writedata = d;
    byteenable = be;
    #1; // decode settled, well before the rising edge
    while (waitrequest) @(negedge clk);
    @(negedge clk); // completion edge is behind us
    read = 1'b0;
    write = 1'b0;
  endtask

  // lsb first, data set up a cycle before the hid_clk rise
  task automatic hid_send(input logic [`HID_W-1:0] w);
    for (int i = 0; i < `HID_W; i++) begin
      @(negedge clk);
      hid_dat = w[i];
      @(negedge clk);
      hid_clk = 1'b1;
      @(negedge clk);
      hid_clk = 1'b0;
    end
  endtask

  initial begin
    reset_n = 1'b0;
    hid_clk = 1'b0;
    hid_dat = 1'b0;
    hid_str = 1'b0;
    ext_irq = '0;
    address = '0;
    read = 1'b0;
    write = 1'b0;
    writedata = '0;
    byteenable = '0;
    repeat (5) @(negedge clk);
    reset_n = 1'b1;
    bus_xfer(1'b1, irq_addr, '0, '0); // nothing pending yet
    bus_xfer(1'b1, hid_addr, '0, '0); // no word arrived
    for (int i = 0; i < n_sram; i++) begin
      random_bits(`SRAM_AW, rnd);
      idx[i] = rnd[`SRAM_AW-1:0];
      random_bits(`DATA_W, rnd);
      bus_xfer(1'b0, sram_addr(idx[i]), rnd, 4'hf); // defined starting value
    end
    for (int i = 0; i < n_sram; i++) begin
      random_bits(`DATA_W, rnd);
      random_bits(`BE_W, rnd_be);
      bus_xfer(1'b0, sram_addr(idx[i]), rnd, rnd_be[`BE_W-1:0]);
    end
    for (int i = 0; i < n_sram; i++) bus_xfer(1'b1, sram_addr(idx[i]), '0, '0);
    // external interrupt edges, both bits pending from here on
    ext_irq[0] = 1'b1;
    repeat (5) @(negedge clk);
    ext_irq[1] = 1'b1;
    repeat (5) @(negedge clk);
    // unmapped regions next to sram and irq
    bus_xfer(1'b0, sram_addr(idx[0]) ^ 32'h0001_0000, 32'hdead_beef, 4'hf);
    bus_xfer(1'b0, irq_addr ^ 32'h0001_0000, 32'hffff_ffff, 4'hf); // pending stays set
    bus_xfer(1'b1, sram_addr(idx[0]) ^ 32'h0001_0000, '0, '0);
    bus_xfer(1'b1, irq_addr ^ 32'h0001_0000, '0, '0);
    bus_xfer(1'b1, sram_addr(idx[0]), '0, '0);
    bus_xfer(1'b1, irq_addr, '0, '0);
    bus_xfer(1'b0, irq_addr, 32'h1, 4'hf); // clear bit 0 only
    repeat (5) @(negedge clk);
    bus_xfer(1'b1, irq_addr, '0, '0); // held level must not set again
    ext_irq[0] = 1'b0;
    repeat (5) @(negedge clk);
    ext_irq[0] = 1'b1;
    repeat (5) @(negedge clk);
    bus_xfer(1'b1, irq_addr, '0, '0);
    bus_xfer(1'b0, irq_addr, 32'h7, 4'hf);
    ext_irq = '0;
    bus_xfer(1'b1, irq_addr, '0, '0);
    // hid word
    random_bits(`HID_W, rnd);
    hid_send(rnd);
    @(negedge clk);
    hid_str = 1'b1;
    repeat (4) @(negedge clk); // arrival takes three clk edges
    bus_xfer(1'b1, hid_addr, '0, '0);
    bus_xfer(1'b1, hid_addr, '0, '0); // consumed, reads zero
    bus_xfer(1'b1, irq_addr, '0, '0);
    hid_str = 1'b0;
    repeat (5) @(negedge clk);
    errors_total = mon.data_errors + mon.timing_errors + dut.chk.fail_count;
    $display("errors: data %0d, timing %0d, assertion %0d",
             mon.data_errors, mon.timing_errors, dut.chk.fail_count);
    if (errors_total == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- test/soc_chk.sv
`timescale 1ns/10ps

module soc_chk (
  input logic              clk,
  input logic              reset_n,
  input logic              waitrequest,
  input logic              irq,
  input irq_pkg::irq_vec_t pending
);

  int wait_fails = 0;
  int irq_fails = 0;
  int reset_fails = 0;
  int fail_count;

  assign fail_count = wait_fails + irq_fails + reset_fails;

  // one wait cycle at most
  wait_once: assert property (@(posedge clk) disable iff (!reset_n)
    waitrequest |=> !waitrequest)
    else begin
      wait_fails++;
      $error("waitrequest stayed high for more than one cycle");
    end

  irq_is_or: assert property (@(posedge clk) disable iff (!reset_n)
    irq == (|pending))
    else begin
      irq_fails++;
      $error("irq does not match the OR of the pending bits");
    end

  quiet_reset: assert property (@(posedge clk) !reset_n |-> !waitrequest && !irq)
    else begin
      reset_fails++;
      $error("waitrequest or irq high during reset");
    end

endmodule

bind soc_top soc_chk chk (
  .clk         (clk),
  .reset_n     (reset_n),
  .waitrequest (waitrequest),
  .irq         (irq),
  .pending     (u_irq.pending)
);

//--- test/soc_monitor.sv
`timescale 1ns/10ps
`include "soc_params.svh"

module soc_monitor (
  input logic               clk,
  input logic               reset_n,
  input logic               hid_clk,
  input logic               hid_dat,
  input logic               hid_str,
  input logic [`IRQ_N-2:0]  ext_irq,
  input logic [`ADDR_W-1:0] address,
  input logic               read,
  input logic               write,
  input logic [`DATA_W-1:0] writedata,
  input logic [`BE_W-1:0]   byteenable,
  input logic [`DATA_W-1:0] readdata,
  input logic               waitrequest,
  input logic               irq
);
  import bus_pkg::*;
  import irq_pkg::*;

  logic [`DATA_W-1:0] shadow [2**`SRAM_AW]; // expected sram contents
  irq_vec_t           pend_m; // expected pending bits
  irq_vec_t           set_m;
  irq_vec_t           clr_m;
  logic [`IRQ_N-2:0]  ext_d1; // line history, one clk apart
  logic [`IRQ_N-2:0]  ext_d2;
  logic [`IRQ_N-2:0]  ext_d3;
  logic [2:0]         str_d; // hid_str history, oldest at top
  logic               hid_req_m;
  logic               arrived_m;
  logic [`HID_W-1:0]  hid_acc; // bits in the order sent
  logic [`HID_W-1:0]  hid_word_m;
  logic [4:0]         hid_cnt = '0;
  logic [`DATA_W-1:0] exp_data;
  int                 exp_wait;
  int                 wait_cnt;
  int                 data_errors = 0;
  int                 timing_errors = 0;

  function automatic slave_e region_of(input logic [`ADDR_W-1:0] a);
    case (a[`REGION_HI:`REGION_LO])
      `BASE_SRAM: return sel_sram;
      `BASE_IRQ:  return sel_irq;
      `BASE_HID:  return sel_hid;
      default:    return sel_none;
    endcase
  endfunction

  function automatic logic [`DATA_W-1:0] merge_bytes(input logic [`DATA_W-1:0] old_w,
      input logic [`DATA_W-1:0] new_w, input logic [`BE_W-1:0] be);
    logic [`DATA_W-1:0] r;
    r = old_w;
    for (int b = 0; b < `BE_W; b++) begin
      if (be[b]) r[8*b +: 8] = new_w[8*b +: 8]; // enabled lanes only
    end
    return r;
  endfunction

  // reference result of a completed read
  function automatic logic [`DATA_W-1:0] expect_read(input logic [`ADDR_W-1:0] a);
    case (region_of(a))
      sel_sram: return shadow[a[`SRAM_AW+1:2]];
      sel_irq:  return `DATA_W'(pend_m);
      sel_hid:  return arrived_m ? `DATA_W'(hid_word_m) : '0; // word once, then zero
      default:  return '0;
    endcase
  endfunction

  always @(posedge hid_clk) begin
    hid_acc[hid_cnt] <= hid_dat; // first bit sent lands in bit 0
    hid_cnt <= hid_cnt + 1'b1;
  end

  always @(posedge clk) begin
    if (write && !waitrequest && region_of(address) == sel_sram)
      shadow[address[`SRAM_AW+1:2]] <= merge_bytes(shadow[address[`SRAM_AW+1:2]],
                                                   writedata, byteenable);
  end

  always @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      pend_m <= '0;
      ext_d1 <= '0;
      ext_d2 <= '0;
      ext_d3 <= '0;
      str_d <= '0;
      hid_req_m <= 1'b0;
      arrived_m <= 1'b0;
      wait_cnt <= 0;
    end else begin
      if (irq !== (|pend_m)) begin
        data_errors++;
        $display("FAIL %0t irq: expected %b, got %b", $time, |pend_m, irq);
      end
      if (waitrequest && !read && !write) begin
        timing_errors++;
        $display("at %0t waitrequest is high with no transfer on the bus", $time);
      end
      if ((read || write) && waitrequest) begin
        wait_cnt <= wait_cnt + 1;
      end else if (read || write) begin
        exp_wait = (read && region_of(address) == sel_sram) ? 1 : 0; // sram read waits once
        if (wait_cnt != exp_wait) begin
          timing_errors++;
          $display("FAIL %0t waitrequest cycles: expected %0d, got %0d",
                   $time, exp_wait, wait_cnt);
        end
        wait_cnt <= 0;
      end
      if (read && !waitrequest) begin
        exp_data = expect_read(address);
        if (readdata !== exp_data) begin
          data_errors++;
          $display("FAIL %0t readdata: expected %h, got %h", $time, exp_data, readdata);
        end
      end
      // pending model, bit order hid, ext1, ext0
      set_m = {hid_req_m, ext_d2 & ~ext_d3};
      clr_m = '0;
      if (write && !waitrequest && region_of(address) == sel_irq &&
          address[`REGION_LO-1:2] == '0)
        clr_m = writedata[`IRQ_N-1:0];
      pend_m <= (pend_m & ~clr_m) | set_m; // a new request beats the clear
      ext_d1 <= ext_irq;
      ext_d2 <= ext_d1;
      ext_d3 <= ext_d2;
      str_d <= {str_d[1:0], hid_str};
      hid_req_m <= str_d[1] && !str_d[2];
      if (str_d[1] && !str_d[2]) begin
        arrived_m <= 1'b1; // third edge after the strobe rises
        hid_word_m <= hid_acc;
      end else if (read && !waitrequest && region_of(address) == sel_hid) begin
        arrived_m <= 1'b0;
      end
    end
  end

endmodule

//--- logic/soc_top.sv
`timescale 1ns/10ps
`include "soc_params.svh"

module soc_top (
  input  logic               clk,
  input  logic               reset_n,
  input  logic               hid_clk,
  input  logic               hid_dat,
  input  logic               hid_str,
  input  logic [`IRQ_N-2:0]  ext_irq,
  input  logic [`ADDR_W-1:0] address,
  input  logic               read,
  input  logic               write,
  input  logic [`DATA_W-1:0] writedata,
  input  logic [`BE_W-1:0]   byteenable,
  output logic [`DATA_W-1:0] readdata,
  output logic               waitrequest,
  output logic               irq
);

  logic               sram_read;
  logic               sram_write;
  logic               irq_write;
  logic               hid_read;
  logic [`DATA_W-1:0] sram_readdata;
  logic               sram_waitrequest;
  logic [`DATA_W-1:0] irq_readdata;
  logic [`DATA_W-1:0] hid_readdata;
  logic               hid_irq_req; // hid arrival into the controller

  bus_decoder u_dec (
    .address          (address),
    .read             (read),
    .write            (write),
    .sram_readdata    (sram_readdata),
    .sram_waitrequest (sram_waitrequest),
    .irq_readdata     (irq_readdata),
    .hid_readdata     (hid_readdata),
    .sram_read        (sram_read),
    .sram_write       (sram_write),
    .irq_write        (irq_write),
    .hid_read         (hid_read),
    .readdata         (readdata),
    .waitrequest      (waitrequest)
  );

  main_sram u_sram (
    .clk              (clk),
    .reset_n          (reset_n),
    .word_addr        (address[`SRAM_AW+1:2]), // word index
    .sram_read        (sram_read),
    .sram_write       (sram_write),
    .writedata        (writedata),
    .byteenable       (byteenable),
    .sram_readdata    (sram_readdata),
    .sram_waitrequest (sram_waitrequest)
  );

  irq_ctrl u_irq (
    .clk          (clk),
    .reset_n      (reset_n),
    .ext_irq      (ext_irq),
    .hid_irq_req  (hid_irq_req),
    .irq_write    (irq_write),
    .writedata    (writedata),
    .irq_readdata (irq_readdata),
    .irq          (irq)
  );

  hid_receiver u_hid (
    .clk          (clk),
    .hid_clk      (hid_clk),
    .reset_n      (reset_n),
    .hid_dat      (hid_dat),
    .hid_str      (hid_str),
    .hid_read     (hid_read),
    .hid_readdata (hid_readdata),
    .hid_irq_req  (hid_irq_req)
  );

endmodule

//--- logic/hid_receiver.sv
`timescale 1ns/10ps
`include "soc_params.svh"

module hid_receiver (
  input  logic               clk,
  input  logic               hid_clk,
  input  logic               reset_n,
  input  logic               hid_dat,
  input  logic               hid_str,
  input  logic               hid_read,
  output logic [`DATA_W-1:0] hid_readdata,
  output logic               hid_irq_req
);

  logic [`HID_W-1:0] shift; // hid_clk domain, stable while hid_str low
  logic              str_meta; // first sync stage
  logic              str_sync; // second sync stage
  logic              str_last; // edge detect
  logic              str_rise;
  logic              arrived;

  // lsb-first serial, new bit enters at the top
  always_ff @(posedge hid_clk) begin
    shift <= {hid_dat, shift[`HID_W-1:1]};
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      str_meta <= 1'b0;
      str_sync <= 1'b0;
      str_last <= 1'b0;
    end else begin
      str_meta <= hid_str;
      str_sync <= str_meta;
      str_last <= str_sync;
    end
  end

  assign str_rise = str_sync && !str_last;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      arrived     <= 1'b0;
      hid_irq_req <= 1'b0;
    end else begin
      hid_irq_req <= str_rise; // single cycle pulse
      if (str_rise) begin
        arrived <= 1'b1; // third clk edge after hid_str rises
      end else if (hid_read) begin
        arrived <= 1'b0; // word consumed
      end
    end
  end

  // word is stable once arrived is set
  assign hid_readdata = arrived ? `DATA_W'(shift) : '0;

endmodule

//--- logic/irq_ctrl.sv
`timescale 1ns/10ps
`include "soc_params.svh"

module irq_ctrl (
  input  logic               clk,
  input  logic               reset_n,
  input  logic [`IRQ_N-2:0]  ext_irq, // async external lines
  input  logic               hid_irq_req, // already in clk
  input  logic               irq_write,
  input  logic [`DATA_W-1:0] writedata,
  output logic [`DATA_W-1:0] irq_readdata,
  output logic               irq
);
  import irq_pkg::*;

  logic [`IRQ_N-2:0] ext_meta; // first sync stage
  logic [`IRQ_N-2:0] ext_sync; // second sync stage
  irq_vec_t          req; // request levels in clk
  irq_vec_t          ack; // level seen last edge, one set per rise
  irq_vec_t          clr; // write-one-to-clear mask
  irq_vec_t          pending;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      ext_meta <= '0;
      ext_sync <= '0;
    end else begin
      ext_meta <= ext_irq;
      ext_sync <= ext_meta;
    end
  end

  always_comb begin
    req           = '0;
    req[src_ext0] = ext_sync[0];
    req[src_ext1] = ext_sync[1];
    req[src_hid]  = hid_irq_req;
  end

  assign clr = irq_write ? irq_vec_t'(writedata[`IRQ_N-1:0]) : '0;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      ack     <= '0;
      pending <= '0;
    end else begin
      ack     <= req; // rearm once the line falls
      pending <= (pending & ~clr) | (req & ~ack); // new set beats clear
    end
  end

  assign irq          = |pending;
  assign irq_readdata = `DATA_W'(pending); // upper bits read zero

endmodule

//--- logic/main_sram.sv
`timescale 1ns/10ps
`include "soc_params.svh"

module main_sram (
  input  logic                clk,
  input  logic                reset_n,
  input  logic [`SRAM_AW-1:0] word_addr,
  input  logic                sram_read,
  input  logic                sram_write,
  input  logic [`DATA_W-1:0]  writedata,
  input  logic [`BE_W-1:0]    byteenable,
  output logic [`DATA_W-1:0]  sram_readdata,
  output logic                sram_waitrequest
);
  import bus_pkg::*;

  logic [`DATA_W-1:0] mem [2**`SRAM_AW]; // contents undefined until written
  sram_state_e        state;

  // byte-lane writes, no wait
  always_ff @(posedge clk) begin
    if (sram_write) begin
      for (int b = 0; b < `BE_W; b++) begin
        if (byteenable[b]) mem[word_addr][8*b +: 8] <= writedata[8*b +: 8];
      end
    end
  end

  // read data register, loaded during the wait cycle
  always_ff @(posedge clk) begin
    if (sram_read && state == sram_idle) sram_readdata <= mem[word_addr];
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state <= sram_idle;
    end else begin
      case (state)
        sram_idle: if (sram_read) state <= sram_ack; // data captured this edge
        sram_ack:  state <= sram_idle; // read completes in ack, drops or restarts
        default:   state <= sram_idle;
      endcase
    end
  end

  assign sram_waitrequest = sram_read && (state == sram_idle); // hold master one cycle

endmodule

//--- logic/bus_decoder.sv
`timescale 1ns/10ps
`include "soc_params.svh"

module bus_decoder (
  input  logic [`ADDR_W-1:0] address,
  input  logic               read,
  input  logic               write,
  input  logic [`DATA_W-1:0] sram_readdata,
  input  logic               sram_waitrequest,
  input  logic [`DATA_W-1:0] irq_readdata,
  input  logic [`DATA_W-1:0] hid_readdata,
  output logic               sram_read,
  output logic               sram_write,
  output logic               irq_write,
  output logic               hid_read,
  output logic [`DATA_W-1:0] readdata,
  output logic               waitrequest
);
  import bus_pkg::*;

  slave_e sel; // decoded target
  logic   irq_reg0; // pending register lives at offset 0

  always_comb begin
    case (address[`REGION_HI:`REGION_LO])
      `BASE_SRAM: sel = sel_sram;
      `BASE_IRQ:  sel = sel_irq;
      `BASE_HID:  sel = sel_hid;
      default:    sel = sel_none; // unmapped
    endcase
  end

  assign irq_reg0 = (address[`REGION_LO-1:2] == '0);

  // per-slave strobes
  assign sram_read  = read && (sel == sel_sram);
  assign sram_write = write && (sel == sel_sram);
  assign irq_write  = write && (sel == sel_irq) && irq_reg0; // other offsets ignored
  assign hid_read   = read && (sel == sel_hid) && !waitrequest; // only a finished read clears arrived

  // response mux
  always_comb begin
    case (sel)
      sel_sram: begin
        readdata    = sram_readdata;
        waitrequest = sram_waitrequest; // one wait cycle on reads
      end
      sel_irq: begin
        readdata    = irq_readdata;
        waitrequest = 1'b0;
      end
      sel_hid: begin
        readdata    = hid_readdata;
        waitrequest = 1'b0;
      end
      default: begin
        readdata    = '0; // unmapped reads zero, no wait
        waitrequest = 1'b0;
      end
    endcase
  end

endmodule

//--- logic/irq_pkg.sv
`include "soc_params.svh"

package irq_pkg;

  // bit positions in the pending register
  typedef enum logic [1:0] {
    src_ext0 = 2'd0,
    src_ext1 = 2'd1,
    src_hid = 2'd2
  } irq_src_e;

  typedef logic [`IRQ_N-1:0] irq_vec_t; // one bit per source

endpackage

//--- logic/bus_pkg.sv
package bus_pkg;

  // target picked by the address decoder
  typedef enum logic [1:0] {
    sel_none, // unmapped, reads zero
    sel_sram,
    sel_irq,
    sel_hid
  } slave_e;

  // sram read phase
  typedef enum logic {
    sram_idle, // waiting for a read, waitrequest raised here
    sram_ack // data registered, transfer completes
  } sram_state_e;

endpackage

//--- logic/soc_params.svh
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// bus widths
`define ADDR_W 32
`define DATA_W 32
`define BE_W 4 // one enable per byte lane

// region field, upper half of the address
`define REGION_HI 31
`define REGION_LO 16

// region codes compared against address[31:16]
`define BASE_SRAM 16'h0200 // main sram, 4 KB used
`define BASE_IRQ 16'h0202 // interrupt controller
`define BASE_HID 16'h0207 // serial hid receiver

// sram word address, taken from address[11:2]
`define SRAM_AW 10

// interrupt sources: two external lines plus hid
`define IRQ_N 3

// hid serial word
`define HID_W 32

`endif
